// File: source/priv_csr_pkg.sv
/*
  CSR addresses, register layouts and access structs of the machine-mode unit.
  Only machine and user privilege exist, so all supervisor fields stay zero.
  CSR_SET and CSR_CLEAR with zero wdata are pure reads, as with rs1 = x0.
*/
`default_nettype none

package priv_csr_pkg;

  typedef logic [11:0] csr_addr_t;

  // Machine information, read only
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR    = 12'hF15;
  // Trap setup
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MSTATUSH_ADDR      = 12'h310;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  // Trap handling
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;
  // Counters
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;

  // MXL = 1, extensions I, M and U
  localparam logic [31:0] MISA_VALUE = 32'h4010_1100;

  typedef enum logic [1:0] {
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_t;

  typedef struct packed {
    csr_op_t     op;
    csr_addr_t   addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        invalid;
  } csr_rsp_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'b00,
    VECTORED = 2'b01
  } vector_mode_t;

  typedef struct packed {
    logic       sd;
    logic [7:0] reserved_3;
    logic       tsr;
    logic       tw;
    logic       tvm;
    logic       mxr;
    logic       sum;
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    logic [1:0] mpp;
    logic [1:0] vs;
    logic       spp;
    logic       mpie;
    logic       ube;
    logic       spie;
    logic       reserved_2;
    logic       mie;
    logic       reserved_1;
    logic       sie;
    logic       reserved_0;
  } mstatus_t;

  typedef struct packed {
    logic [29:0]  base;
    vector_mode_t mode;
  } mtvec_t;

  typedef struct packed {
    logic [15:0] impl_defined;
    logic [3:0]  zero_6;
    logic        meie;
    logic        zero_5;
    logic        seie;
    logic        zero_4;
    logic        mtie;
    logic        zero_3;
    logic        stie;
    logic        zero_2;
    logic        msie;
    logic        zero_1;
    logic        ssie;
    logic        zero_0;
  } mie_t;

  typedef struct packed {
    logic [15:0] impl_defined;
    logic [3:0]  zero_6;
    logic        meip;
    logic        zero_5;
    logic        seip;
    logic        zero_4;
    logic        mtip;
    logic        zero_3;
    logic        stip;
    logic        zero_2;
    logic        msip;
    logic        zero_1;
    logic        ssip;
    logic        zero_0;
  } mip_t;

  typedef struct packed {
    logic [28:0] hpm;
    logic        ir;
    logic        zero;
    logic        cy;
  } mcountinhibit_t;

endpackage

`default_nettype wire

// File: source/priv_trap_pkg.sv
/*
  Privilege levels, cause codes and the structs exchanged between the
  trap controller, the CSR file and the core.
  Causes are the 31-bit code only, the interrupt bit travels separately.
*/
`default_nettype none

package priv_trap_pkg;

  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    M_MODE = 2'b11
  } priv_level_t;

  // Exception codes
  localparam logic [30:0] CAUSE_ILLEGAL_INST = 31'd2;
  localparam logic [30:0] CAUSE_ECALL_U      = 31'd8;
  localparam logic [30:0] CAUSE_ECALL_M      = 31'd11;
  // Interrupt codes
  localparam logic [30:0] IRQ_MSI = 31'd3;
  localparam logic [30:0] IRQ_MTI = 31'd7;
  localparam logic [30:0] IRQ_MEI = 31'd11;

  typedef struct packed {
    logic [30:0] cause;
    logic [31:0] tval;
    logic [31:0] epc;
  } exc_t;

  typedef struct packed {
    logic meip;
    logic mtip;
    logic msip;
  } irq_lines_t;

  typedef struct packed {
    logic                 mie;
    logic                 mpie;
    priv_level_t          mpp;
    irq_lines_t           irq_pend;  // Pending and enabled
    priv_csr_pkg::mtvec_t tvec;
    logic [31:0]          mepc;
    logic [30:0]          cause;     // Last mcause value, debug only
  } trap_state_t;

  typedef struct packed {
    logic        take;
    logic        mret;
    logic        intr;
    logic [30:0] cause;
    logic [31:0] epc;
    logic [31:0] tval;
    priv_level_t prev_priv;
  } trap_update_t;

  typedef struct packed {
    logic [31:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// File: source/priv_irq_sync.sv
/*
  Flip-flop synchronizer for the asynchronous interrupt lines.
  Each line is a plain level, so no pulse shorter than a clock is caught.
  SYNC_STAGES must be 2 or more.
*/
`default_nettype none

module priv_irq_sync #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  priv_trap_pkg::irq_lines_t irq,
  output priv_trap_pkg::irq_lines_t irq_sync
);

  import priv_trap_pkg::*;

  irq_lines_t sync_q [SYNC_STAGES];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= irq;  // First stage may go metastable
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign irq_sync = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: source/priv_csr_file.sv
/*
  Machine CSR file with WARL legalization, privilege check and counters.
  Set or clear with zero wdata is a read and is allowed on read-only CSRs.
  An invalid access returns zero and changes nothing.
  A trap update must not coincide with a CSR request.
*/
`default_nettype none

module priv_csr_file #(
  parameter logic [31:0] HARTID = '0
) (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        csr_req_valid,
  input  priv_csr_pkg::csr_req_t      csr_req,
  input  priv_trap_pkg::irq_lines_t   irq_sync,
  input  priv_trap_pkg::trap_update_t trap_upd,
  input  priv_trap_pkg::priv_level_t  priv,
  input  logic                        inst_ret,
  output logic                        csr_rsp_valid,
  output priv_csr_pkg::csr_rsp_t      csr_rsp,
  output priv_trap_pkg::trap_state_t  trap_state
);

  import priv_csr_pkg::*;
  import priv_trap_pkg::*;

  logic           mstat_mie;
  logic           mstat_mpie;
  priv_level_t    mstat_mpp;
  mtvec_t         tvec_q;
  mie_t           mie_q;
  logic           msip_sw;   // Software part of mip.msip
  logic [31:0]    mscratch_q;
  logic [31:0]    mepc_q;
  logic [31:0]    mcause_q;
  logic [31:0]    mtval_q;
  logic [31:0]    mcounteren_q;
  mcountinhibit_t inhibit_q;
  logic [63:0]    cycle_q;
  logic [63:0]    cycle_next;
  logic [63:0]    instret_q;
  logic [63:0]    instret_next;

  mstatus_t       mstatus;
  mip_t           mip;
  logic [31:0]    rdata;
  logic [31:0]    wval;
  logic           known;
  logic           do_write;
  logic           invalid;
  logic           csr_we;

  // Architectural views of the sparse registers
  always_comb begin
    mstatus      = '0;
    mstatus.mie  = mstat_mie;
    mstatus.mpie = mstat_mpie;
    mstatus.mpp  = mstat_mpp;

    mip      = '0;
    mip.meip = irq_sync.meip;
    mip.mtip = irq_sync.mtip;
    mip.msip = msip_sw | irq_sync.msip;
  end

  // Read mux, also the old value for set and clear
  always_comb begin
    rdata = '0;
    known = 1'b1;
    case (csr_req.addr)
      MSTATUS_ADDR:       rdata = mstatus;
      MISA_ADDR:          rdata = MISA_VALUE;
      MIE_ADDR:           rdata = mie_q;
      MTVEC_ADDR:         rdata = tvec_q;
      MCOUNTEREN_ADDR:    rdata = mcounteren_q;
      MSTATUSH_ADDR:      rdata = '0;  // Little endian only
      MCOUNTINHIBIT_ADDR: rdata = inhibit_q;
      MSCRATCH_ADDR:      rdata = mscratch_q;
      MEPC_ADDR:          rdata = mepc_q;
      MCAUSE_ADDR:        rdata = mcause_q;
      MTVAL_ADDR:         rdata = mtval_q;
      MIP_ADDR:           rdata = mip;
      MCYCLE_ADDR:        rdata = cycle_q[31:0];
      MCYCLEH_ADDR:       rdata = cycle_q[63:32];
      MINSTRET_ADDR:      rdata = instret_q[31:0];
      MINSTRETH_ADDR:     rdata = instret_q[63:32];
      MHARTID_ADDR:       rdata = HARTID;
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR: rdata = '0;
      default:            known = 1'b0;
    endcase
  end

  // Merge with the old value and check access rights
  always_comb begin
    do_write = (csr_req.op == CSR_WRITE) || (csr_req.wdata != '0);
    case (csr_req.op)
      CSR_WRITE: wval = csr_req.wdata;
      CSR_SET:   wval = rdata | csr_req.wdata;
      CSR_CLEAR: wval = rdata & ~csr_req.wdata;
      default:   wval = rdata;
    endcase
    invalid = !known
            || (csr_req.addr[9:8] > priv)                       // Needs more privilege
            || ((csr_req.addr[11:10] == 2'b11) && do_write);    // Read-only space
    csr_we = csr_req_valid && do_write && !invalid;
  end

  // Counters, a CSR write to either half wins over the increment
  always_comb begin
    cycle_next   = cycle_q + {63'd0, ~inhibit_q.cy};
    instret_next = instret_q + {63'd0, inst_ret & ~inhibit_q.ir};
    if (csr_we) begin
      case (csr_req.addr)
        MCYCLE_ADDR:    cycle_next[31:0]    = wval;
        MCYCLEH_ADDR:   cycle_next[63:32]   = wval;
        MINSTRET_ADDR:  instret_next[31:0]  = wval;
        MINSTRETH_ADDR: instret_next[63:32] = wval;
        default:        ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstat_mie    <= 1'b0;
      mstat_mpie   <= 1'b0;
      mstat_mpp    <= M_MODE;
      tvec_q       <= '{base: '0, mode: DIRECT};
      mie_q        <= '0;
      msip_sw      <= 1'b0;
      mscratch_q   <= '0;
      mepc_q       <= '0;
      mcause_q     <= '0;
      mtval_q      <= '0;
      mcounteren_q <= '0;
      inhibit_q    <= '{hpm: '0, ir: 1'b1, zero: 1'b0, cy: 1'b1};
      cycle_q      <= '0;
      instret_q    <= '0;
    end else begin
      cycle_q   <= cycle_next;
      instret_q <= instret_next;

      if (csr_we) begin
        case (csr_req.addr)
          MSTATUS_ADDR: begin
            mstat_mie  <= wval[3];
            mstat_mpie <= wval[7];
            mstat_mpp  <= (wval[12:11] == 2'b11) ? M_MODE : U_MODE;  // No S-mode
          end
          MTVEC_ADDR: begin
            tvec_q.base <= wval[31:2];
            tvec_q.mode <= (wval[1:0] == 2'b01) ? VECTORED : DIRECT;
          end
          MIE_ADDR: begin
            mie_q.meie <= wval[11];
            mie_q.mtie <= wval[7];
            mie_q.msie <= wval[3];
          end
          MIP_ADDR:           msip_sw      <= wval[3];
          MCOUNTEREN_ADDR:    mcounteren_q <= wval & 32'h7;
          MCOUNTINHIBIT_ADDR: begin
            inhibit_q.cy <= wval[0];
            inhibit_q.ir <= wval[2];
          end
          MSCRATCH_ADDR:      mscratch_q <= wval;
          MEPC_ADDR:          mepc_q     <= {wval[31:2], 2'b00};
          MCAUSE_ADDR:        mcause_q   <= wval;
          MTVAL_ADDR:         mtval_q    <= wval;
          default:            ;
        endcase
      end

      // Trap entry and return
      if (trap_upd.take) begin
        mstat_mpie <= mstat_mie;
        mstat_mie  <= 1'b0;
        mstat_mpp  <= trap_upd.prev_priv;
        mepc_q     <= {trap_upd.epc[31:2], 2'b00};
        mcause_q   <= {trap_upd.intr, trap_upd.cause};
        mtval_q    <= trap_upd.tval;
      end else if (trap_upd.mret) begin
        mstat_mie  <= mstat_mpie;
        mstat_mpie <= 1'b1;
        mstat_mpp  <= U_MODE;
      end
    end
  end

  // Registered response
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      csr_rsp_valid <= 1'b0;
    end else begin
      csr_rsp_valid <= csr_req_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (csr_req_valid) begin
      csr_rsp.rdata   <= invalid ? '0 : rdata;
      csr_rsp.invalid <= invalid;
    end
  end

  // State for the trap controller
  always_comb begin
    trap_state.mie           = mstat_mie;
    trap_state.mpie          = mstat_mpie;
    trap_state.mpp           = mstat_mpp;
    trap_state.irq_pend.meip = mip.meip & mie_q.meie;
    trap_state.irq_pend.mtip = mip.mtip & mie_q.mtie;
    trap_state.irq_pend.msip = mip.msip & mie_q.msie;
    trap_state.tvec          = tvec_q;
    trap_state.mepc          = mepc_q;
    trap_state.cause         = mcause_q[30:0];
  end

endmodule

`default_nettype wire

// File: source/priv_trap_ctrl.sv
/*
  Trap and mret sequencing with the current privilege register.
  Interrupts are only taken on a retire strobe, epc is then ret_pc.
  Exception beats interrupt, mret comes last. Priority MEI, MSI, MTI.
*/
`default_nettype none

module priv_trap_ctrl (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        exc_valid,
  input  priv_trap_pkg::exc_t         exc,
  input  logic                        mret,
  input  logic                        inst_ret,
  input  logic [31:0]                 ret_pc,
  input  priv_trap_pkg::trap_state_t  trap_state,
  output priv_trap_pkg::trap_update_t trap_upd,
  output priv_trap_pkg::priv_level_t  priv,
  output logic                        redirect_valid,
  output priv_trap_pkg::redirect_t    redirect
);

  import priv_csr_pkg::*;
  import priv_trap_pkg::*;

  logic        irq_take;
  logic        take;
  logic [30:0] irq_cause;
  logic [31:0] tvec_base;
  logic [31:0] target;

  always_comb begin
    // M-mode needs the global enable, U-mode always takes
    irq_take = inst_ret && (trap_state.mie || (priv == U_MODE)) && (|trap_state.irq_pend);
    take     = exc_valid || irq_take;

    if (trap_state.irq_pend.meip) begin
      irq_cause = IRQ_MEI;
    end else if (trap_state.irq_pend.msip) begin
      irq_cause = IRQ_MSI;
    end else begin
      irq_cause = IRQ_MTI;
    end

    trap_upd.take      = take;
    trap_upd.mret      = mret && !take;
    trap_upd.intr      = !exc_valid && irq_take;
    trap_upd.cause     = exc_valid ? exc.cause : irq_cause;
    trap_upd.epc       = exc_valid ? exc.epc : ret_pc;
    trap_upd.tval      = exc_valid ? exc.tval : '0;
    trap_upd.prev_priv = priv;

    tvec_base = {trap_state.tvec.base, 2'b00};
    if (!take) begin
      target = trap_state.mepc;  // mret
    end else if (trap_upd.intr && (trap_state.tvec.mode == VECTORED)) begin
      target = tvec_base + {trap_upd.cause[29:0], 2'b00};
    end else begin
      target = tvec_base;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      priv           <= M_MODE;
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= take || mret;
      if (take) begin
        priv <= M_MODE;
      end else if (mret) begin
        priv <= trap_state.mpp;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (take || mret) begin
      redirect.target <= target;
    end
  end

endmodule

`default_nettype wire

// File: source/priv_unit.sv
/*
  Machine-mode privilege unit, M and U privilege only.
  No back-pressure. The core must not send a CSR request in the same
  cycle as an exception, mret or a retire that takes an interrupt.
*/
`default_nettype none

module priv_unit #(
  parameter logic [31:0] HARTID      = '0,
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       csr_req_valid,
  input  priv_csr_pkg::csr_req_t     csr_req,
  output logic                       csr_rsp_valid,
  output priv_csr_pkg::csr_rsp_t     csr_rsp,
  input  logic                       exc_valid,
  input  priv_trap_pkg::exc_t        exc,
  input  logic                       mret,
  input  logic                       inst_ret,
  input  logic [31:0]                ret_pc,
  input  priv_trap_pkg::irq_lines_t  irq,
  output logic                       redirect_valid,
  output priv_trap_pkg::redirect_t   redirect,
  output priv_trap_pkg::priv_level_t priv
);

  import priv_trap_pkg::*;

  irq_lines_t   irq_sync;
  trap_state_t  trap_state;
  trap_update_t trap_upd;

  priv_irq_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) irq_sync_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .irq      (irq),
    .irq_sync (irq_sync)
  );

  priv_csr_file #(
    .HARTID (HARTID)
  ) csr_file_inst (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_req_valid (csr_req_valid),
    .csr_req       (csr_req),
    .irq_sync      (irq_sync),
    .trap_upd      (trap_upd),
    .priv          (priv),
    .inst_ret      (inst_ret),
    .csr_rsp_valid (csr_rsp_valid),
    .csr_rsp       (csr_rsp),
    .trap_state    (trap_state)
  );

  priv_trap_ctrl trap_ctrl_inst (
    .CLK            (CLK),
    .nRST           (nRST),
    .exc_valid      (exc_valid),
    .exc            (exc),
    .mret           (mret),
    .inst_ret       (inst_ret),
    .ret_pc         (ret_pc),
    .trap_state     (trap_state),
    .trap_upd       (trap_upd),
    .priv           (priv),
    .redirect_valid (redirect_valid),
    .redirect       (redirect)
  );

endmodule

`default_nettype wire

// File: test/priv_unit_asserts.sv
/*
  Concurrent checks on the top-level strobes of the privilege unit.
  Bound into every priv_unit instance. Checks are off while nRST is low.
  failures counts the assertion failures for the testbench summary.
*/
`default_nettype none

module priv_unit_asserts (
  input logic                        CLK,
  input logic                        nRST,
  input logic                        csr_req_valid,
  input logic                        csr_rsp_valid,
  input logic                        exc_valid,
  input logic                        mret,
  input logic                        redirect_valid,
  input priv_trap_pkg::trap_update_t trap_upd
);

  int failures = 0;

  // Response is exactly one cycle behind its request
  rsp_after_req: assert property (@(posedge CLK) disable iff (!nRST)
    csr_rsp_valid |-> $past(csr_req_valid))
    else begin
      failures++;
      $error("CSR response without a request one cycle earlier");
    end

  redirect_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
    redirect_valid |=> !redirect_valid)
    else begin
      failures++;
      $error("Redirect valid high on two cycles in a row");
    end

  // No back-pressure, so requests and trap events must not overlap
  no_req_with_trap: assert property (@(posedge CLK) disable iff (!nRST)
    csr_req_valid |-> !(exc_valid || mret || trap_upd.take))
    else begin
      failures++;
      $error("CSR request in the same cycle as a trap event");
    end

endmodule

bind priv_unit priv_unit_asserts asserts_inst (
  .CLK            (CLK),
  .nRST           (nRST),
  .csr_req_valid  (csr_req_valid),
  .csr_rsp_valid  (csr_rsp_valid),
  .exc_valid      (exc_valid),
  .mret           (mret),
  .redirect_valid (redirect_valid),
  .trap_upd       (trap_upd)
);

`default_nettype wire

// File: test/priv_unit_tb.sv
/*
  Directed testbench for the machine-mode privilege unit.
  Inputs change and outputs are read 10 time units after the rising edge.
  Tests run in order and each one starts from the state the previous left.
*/
`default_nettype none

module priv_unit_tb;

  import priv_csr_pkg::*;
  import priv_trap_pkg::*;

  localparam int SYNC_STAGES = 2;
  localparam int MAX_CYCLES  = 400;  // Full sequence takes about 100 cycles

  logic        CLK;
  logic        nRST;
  logic        csr_req_valid;
  csr_req_t    csr_req;
  logic        csr_rsp_valid;
  csr_rsp_t    csr_rsp;
  logic        exc_valid;
  exc_t        exc;
  logic        mret;
  logic        inst_ret;
  logic [31:0] ret_pc;
  irq_lines_t  irq;
  logic        redirect_valid;
  redirect_t   redirect;
  priv_level_t priv;

  logic [31:0] lfsr_state;
  logic [31:0] tvec_base;    // Expected trap base
  logic [31:0] scratch_exp;  // Expected mscratch
  logic [31:0] mepc_exp;     // Expected mepc
  int          check_count;
  int          error_count;
  int          cycle_count;

  priv_unit #(
    .HARTID      (32'd5),
    .SYNC_STAGES (SYNC_STAGES)
  ) priv_unit_inst (
    .CLK            (CLK),
    .nRST           (nRST),
    .csr_req_valid  (csr_req_valid),
    .csr_req        (csr_req),
    .csr_rsp_valid  (csr_rsp_valid),
    .csr_rsp        (csr_rsp),
    .exc_valid      (exc_valid),
    .exc            (exc),
    .mret           (mret),
    .inst_ret       (inst_ret),
    .ret_pc         (ret_pc),
    .irq            (irq),
    .redirect_valid (redirect_valid),
    .redirect       (redirect),
    .priv           (priv)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout, the tests did not end within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] next_word();
    logic [31:0] word;
    logic        fb;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      word       = {word[30:0], fb};
    end
    return word;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #10;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("FAIL %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic csr_access(input csr_op_t op, input csr_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic invalid);
    int waited;
    waited        = 0;
    csr_req_valid = 1'b1;
    csr_req.op    = op;
    csr_req.addr  = addr;
    csr_req.wdata = wdata;
    @(posedge CLK);
    #10;
    csr_req_valid = 1'b0;
    while (!csr_rsp_valid && waited < 4) begin
      @(posedge CLK);
      #10;
      waited++;
    end
    assert (csr_rsp_valid) else begin
      error_count++;
      $display("No CSR response arrived for address 0x%03h", addr);
    end
    check_value("CSR response latency", waited, 0);
    rdata   = csr_rsp.rdata;
    invalid = csr_rsp.invalid;
  endtask

  // Set with zero data is a plain read
  task automatic csr_read(input csr_addr_t addr, output logic [31:0] rdata);
    logic invalid;
    csr_access(CSR_SET, addr, 32'd0, rdata, invalid);
    check_value("invalid flag on read", {31'd0, invalid}, 0);
  endtask

  task automatic csr_write(input csr_addr_t addr, input logic [31:0] wdata);
    logic [31:0] old;
    logic        invalid;
    csr_access(CSR_WRITE, addr, wdata, old, invalid);
    check_value("invalid flag on write", {31'd0, invalid}, 0);
  endtask

  task automatic wait_redirect(input logic [31:0] exp_target, input string what);
    int waited;
    waited = 0;
    while (!redirect_valid && waited < 4) begin
      @(posedge CLK);
      #10;
      waited++;
    end
    assert (redirect_valid) else begin
      error_count++;
      $display("No redirect arrived after the %s", what);
    end
    check_value({what, " redirect latency"}, waited, 0);
    check_value({what, " redirect target"}, redirect.target, exp_target);
    idle_cycles(1);  // Core refetches before the next event
  endtask

  task automatic raise_exception(input logic [30:0] cause, input logic [31:0] tval,
                                 input logic [31:0] epc, input logic [31:0] exp_target);
    exc_valid = 1'b1;
    exc.cause = cause;
    exc.tval  = tval;
    exc.epc   = epc;
    @(posedge CLK);
    #10;
    exc_valid = 1'b0;
    wait_redirect(exp_target, "exception");
    check_value("priv after trap", {30'd0, priv}, {30'd0, M_MODE});
  endtask

  task automatic return_from_trap(input logic [31:0] exp_target,
                                  input priv_level_t exp_priv);
    mret = 1'b1;
    @(posedge CLK);
    #10;
    mret = 1'b0;
    wait_redirect(exp_target, "mret");
    check_value("priv after mret", {30'd0, priv}, {30'd0, exp_priv});
  endtask

  task automatic retire(input logic [31:0] pc);
    inst_ret = 1'b1;
    ret_pc   = pc;
    @(posedge CLK);
    #10;
    inst_ret = 1'b0;
  endtask

  task automatic verify_reset_state();
    logic [31:0] rdata;
    logic [31:0] misa_exp;
    misa_exp = (32'd1 << 30) | (32'd1 << 8) | (32'd1 << 12) | (32'd1 << 20);  // RV32 I M U
    csr_read(MHARTID_ADDR, rdata);
    check_value("mhartid", rdata, 32'd5);
    csr_read(MISA_ADDR, rdata);
    check_value("misa", rdata, misa_exp);
    csr_read(MSTATUS_ADDR, rdata);
    check_value("mstatus.mpp after reset", {30'd0, rdata[12:11]}, {30'd0, M_MODE});
    check_value("priv after reset", {30'd0, priv}, {30'd0, M_MODE});
    csr_read(MCYCLE_ADDR, rdata);
    check_value("mcycle after reset", rdata, 0);
    csr_read(MINSTRET_ADDR, rdata);
    check_value("minstret after reset", rdata, 0);
    idle_cycles(5);
    repeat (3) retire(32'h0000_0100);
    csr_read(MCYCLE_ADDR, rdata);
    check_value("mcycle while inhibited", rdata, 0);
    csr_read(MCYCLEH_ADDR, rdata);
    check_value("mcycleh while inhibited", rdata, 0);
    csr_read(MINSTRET_ADDR, rdata);
    check_value("minstret while inhibited", rdata, 0);
  endtask

  task automatic merge_scratch_ops();
    csr_op_t     op;
    logic [31:0] model;
    logic [31:0] data;
    logic [31:0] rdata;
    logic        invalid;
    model = 32'd0;
    for (int i = 0; i < 3; i++) begin
      op   = (i == 0) ? CSR_WRITE : (i == 1) ? CSR_SET : CSR_CLEAR;
      data = next_word();
      csr_access(op, MSCRATCH_ADDR, data, rdata, invalid);
      check_value("mscratch old value", rdata, model);
      check_value("mscratch invalid flag", {31'd0, invalid}, 0);
      case (op)
        CSR_WRITE: model = data;
        CSR_SET:   model = model | data;
        default:   model = model & ~data;
      endcase
      csr_read(MSCRATCH_ADDR, rdata);
      check_value("mscratch merged value", rdata, model);
    end
    scratch_exp = model;
    csr_write(MSTATUS_ADDR, 32'h0000_1000);  // mpp = 2
    csr_read(MSTATUS_ADDR, rdata);
    check_value("mstatus.mpp after writing 2", {30'd0, rdata[12:11]}, 0);
    data      = next_word();
    tvec_base = {data[31:2], 2'b00};
    csr_write(MTVEC_ADDR, {data[31:2], 2'b11});
    csr_read(MTVEC_ADDR, rdata);
    check_value("mtvec after writing mode 3", rdata, tvec_base);
  endtask

  task automatic reject_invalid_access();
    logic [31:0] epc;
    logic [31:0] rdata;
    logic        invalid;
    csr_access(CSR_WRITE, 12'h3A0, next_word(), rdata, invalid);  // No PMP here
    check_value("unknown address invalid flag", {31'd0, invalid}, 1);
    check_value("unknown address data", rdata, 0);
    csr_read(MSCRATCH_ADDR, rdata);
    check_value("mscratch after invalid access", rdata, scratch_exp);
    csr_access(CSR_WRITE, MHARTID_ADDR, next_word(), rdata, invalid);
    check_value("mhartid write invalid flag", {31'd0, invalid}, 1);
    check_value("mhartid write data", rdata, 0);
    csr_read(MHARTID_ADDR, rdata);
    check_value("mhartid after write", rdata, 32'd5);
    epc = next_word();
    csr_write(MEPC_ADDR, epc);
    epc[1:0] = 2'b00;
    mepc_exp = epc;
    csr_read(MEPC_ADDR, rdata);
    check_value("mepc alignment", rdata, epc);
    return_from_trap(epc, U_MODE);  // mpp is U since the WARL write
    csr_access(CSR_SET, MSCRATCH_ADDR, 32'd0, rdata, invalid);
    check_value("mscratch from U-mode invalid flag", {31'd0, invalid}, 1);
    check_value("mscratch from U-mode data", rdata, 0);
    // The core answers the refused access with an illegal instruction trap
    raise_exception(CAUSE_ILLEGAL_INST, 32'h3400_2073, epc, tvec_base);
  endtask

  task automatic ecall_round_trip();
    logic [31:0] data;
    logic [31:0] epc;
    logic [31:0] rdata;
    data      = next_word();
    tvec_base = {data[31:2], 2'b00};
    csr_write(MTVEC_ADDR, tvec_base);
    return_from_trap(mepc_exp, U_MODE);  // mepc still holds the refused access
    data = next_word();
    epc  = {data[31:2], 2'b00};
    raise_exception(CAUSE_ECALL_U, 32'd0, epc, tvec_base);
    csr_read(MEPC_ADDR, rdata);
    check_value("mepc after ecall", rdata, epc);
    csr_read(MCAUSE_ADDR, rdata);
    check_value("mcause after ecall", rdata, 32'd8);
    csr_read(MTVAL_ADDR, rdata);
    check_value("mtval after ecall", rdata, 0);
    csr_read(MSTATUS_ADDR, rdata);
    check_value("mstatus.mpp after ecall", {30'd0, rdata[12:11]}, {30'd0, U_MODE});
    return_from_trap(epc, U_MODE);
  endtask

  task automatic vectored_irq_entry();
    logic [31:0] data;
    logic [31:0] pc;
    logic [31:0] rdata;
    raise_exception(CAUSE_ECALL_U, 32'd0, 32'h0000_0200, tvec_base);  // Back to M-mode
    data      = next_word();
    tvec_base = {data[31:2], 2'b00};
    csr_write(MTVEC_ADDR, tvec_base | 32'd1);
    csr_write(MIE_ADDR, 32'd1 << 11);
    csr_write(MSTATUS_ADDR, 32'd1 << 3);
    irq.meip = 1'b1;
    idle_cycles(SYNC_STAGES);
    data = next_word();
    pc   = {data[31:2], 2'b00};
    retire(pc);
    wait_redirect(tvec_base + 32'd4 * 32'd11, "interrupt");
    check_value("priv after interrupt", {30'd0, priv}, {30'd0, M_MODE});
    csr_read(MCAUSE_ADDR, rdata);
    check_value("mcause after interrupt", rdata, {1'b1, 31'd11});
    csr_read(MEPC_ADDR, rdata);
    check_value("mepc after interrupt", rdata, pc);
    csr_read(MIP_ADDR, rdata);
    check_value("mip.meip", {31'd0, rdata[11]}, 1);
    irq.meip = 1'b0;
    csr_write(MIE_ADDR, 32'd0);
  endtask

  task automatic count_cycles_and_retires();
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] rdata;
    int          strobes;
    int          gap;
    strobes = 3 + int'(next_word() % 6);
    gap     = 4 + int'(next_word() % 12);
    csr_write(MCOUNTINHIBIT_ADDR, 32'd0);
    for (int i = 0; i < strobes; i++) begin
      retire(32'h0000_0400 + 32'd4 * i);
      check_value("redirect on plain retire", {31'd0, redirect_valid}, 0);
    end
    csr_read(MINSTRET_ADDR, rdata);
    check_value("minstret", rdata, strobes);
    csr_read(MCYCLE_ADDR, first);
    idle_cycles(gap - 1);  // Requests land gap cycles apart
    csr_read(MCYCLE_ADDR, second);
    check_value("mcycle difference", second - first, gap);
  endtask

  initial begin
    nRST          = 1'b0;
    csr_req_valid = 1'b0;
    csr_req       = '0;
    exc_valid     = 1'b0;
    exc           = '0;
    mret          = 1'b0;
    inst_ret      = 1'b0;
    ret_pc        = '0;
    irq           = '0;
    lfsr_state    = 32'd48;
    tvec_base     = '0;
    scratch_exp   = '0;
    mepc_exp      = '0;
    check_count   = 0;
    error_count   = 0;
    cycle_count   = 0;
    repeat (10) @(posedge CLK);
    #10;
    nRST = 1'b1;

    verify_reset_state();
    merge_scratch_ops();
    reject_invalid_access();
    ecall_round_trip();
    vectored_irq_entry();
    count_cycles_and_retires();

    $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
             error_count, priv_unit_inst.asserts_inst.failures);
    if (error_count == 0 && priv_unit_inst.asserts_inst.failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
source/priv_csr_pkg.sv
source/priv_trap_pkg.sv
source/priv_irq_sync.sv
source/priv_csr_file.sv
source/priv_trap_ctrl.sv
source/priv_unit.sv
test/priv_unit_asserts.sv
test/priv_unit_tb.sv
